// ==== source/tcb_mem_stage.sv ====
module tcb_mem_stage
  import tcb_pkg::*;
#(
  parameter int unsigned ABW = 12
)(
  input  logic     tcb,
  input  logic     rst_n,
  // from the request stage
  tcb_stage_if.dst req,
  // to the response stage
  tcb_stage_if.src mem
);

  //////////////////////////////
  // word array
  //////////////////////////////

  localparam int unsigned DEPTH = 2**(ABW-2);

  tcb_data_u ram [0:DEPTH-1];

  // byte enabled write
  always_ff @(posedge tcb) begin
    if (req.vld && req.wen) begin
      for (int i = 0; i < tcb_bew; i++) begin
        if (req.ben[i]) begin
          ram[req.idx].lane[i] <= req.dat.lane[i];
        end
      end
    end
  end

  // registered read of the whole word
  // lane selection happens in the response stage
  always_ff @(posedge tcb) begin
    if (req.vld && !req.wen) begin
      mem.dat <= ram[req.idx];
    end
  end

  //////////////////////////////
  // control forwarding
  //////////////////////////////

  // valid bit
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      mem.vld <= 1'b0;
    end else begin
      mem.vld <= req.vld;
    end
  end

  // the rest of the transfer follows one cycle behind
  always_ff @(posedge tcb) begin
    if (req.vld) begin
      mem.wen <= req.wen;
      mem.err <= req.err;
      mem.idx <= req.idx;
      mem.off <= req.off;
      mem.siz <= req.siz;
      mem.ben <= req.ben;
    end
  end

  // an error transfer arriving here must carry no lanes
  // ben was cleared in the request stage a cycle earlier
  a_no_err_write: assert property (
    @(posedge tcb) disable iff (!rst_n)
    (req.vld && req.err) |-> (req.ben == '0)
  );

endmodule : tcb_mem_stage

// ==== source/tcb_mem_sub.sv ====
module tcb_mem_sub
  import tcb_pkg::*;
#(
  parameter int unsigned ABW = 12,
  parameter int unsigned DLY = 3
)(
  input  logic               tcb,
  input  logic               rst_n,
  // request
  input  logic               vld,
  input  logic               wen,
  input  logic [ABW-1:0]     adr,
  input  logic [1:0]         siz,
  input  logic [tcb_dbw-1:0] wdt,
  output logic               rdy,
  // response
  output logic               rsp,
  output logic [tcb_dbw-1:0] rdt,
  output logic               err
);

  //////////////////////////////
  // stage links
  //////////////////////////////

  // request stage to memory stage
  tcb_stage_if #(.ABW (ABW)) req_if ();

  // memory stage to response stage
  tcb_stage_if #(.ABW (ABW)) mem_if ();

  //////////////////////////////
  // pipeline
  //////////////////////////////

  // check, align, register
  tcb_req_stage #(
    .ABW   (ABW)
  ) u_req (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .siz   (siz),
    .wdt   (wdt),
    .rdy   (rdy),
    .req   (req_if.src)
  );

  // word array access
  tcb_mem_stage #(
    .ABW   (ABW)
  ) u_mem (
    .tcb   (tcb),
    .rst_n (rst_n),
    .req   (req_if.dst),
    .mem   (mem_if.src)
  );

  // lane extract and remaining delay
  tcb_rsp_stage #(
    .DLY   (DLY),
    .ABW   (ABW)
  ) u_rsp (
    .tcb   (tcb),
    .rst_n (rst_n),
    .mem   (mem_if.dst),
    .rsp   (rsp),
    .rdt   (rdt),
    .err   (err)
  );

endmodule : tcb_mem_sub

// ==== source/tcb_pkg.sv ====
package tcb_pkg;

  //////////////////////////////
  // bus widths
  //////////////////////////////

  // data bus width in bits
  localparam int unsigned tcb_dbw = 32;

  // number of byte lanes
  localparam int unsigned tcb_bew = tcb_dbw / 8;

  //////////////////////////////
  // transfer size codes
  //////////////////////////////

  // siz is log2 of the byte count
  localparam logic [1:0] tcb_siz_byte = 2'd0;
  localparam logic [1:0] tcb_siz_half = 2'd1;
  localparam logic [1:0] tcb_siz_word = 2'd2;
  // code 3 would be a double word, not supported on a 32-bit bus

  //////////////////////////////
  // data word
  //////////////////////////////

  // one bus word, seen whole or as byte lanes
  // lane 0 holds the least significant byte
  typedef union packed {
    logic [tcb_dbw-1:0]        wrd;
    logic [tcb_bew-1:0][7:0]   lane;
  } tcb_data_u;

endpackage : tcb_pkg

// ==== source/tcb_req_stage.sv ====
module tcb_req_stage
  import tcb_pkg::*;
#(
  parameter int unsigned ABW = 12
)(
  input  logic               tcb,
  input  logic               rst_n,
  // request from the manager
  input  logic               vld,
  input  logic               wen,
  input  logic [ABW-1:0]     adr,
  input  logic [1:0]         siz,
  input  logic [tcb_dbw-1:0] wdt,
  output logic               rdy,
  // to the memory stage
  tcb_stage_if.src           req
);

  //////////////////////////////
  // handshake
  //////////////////////////////

  // transfer on this edge
  logic trn;

  // ready comes up on the first edge after reset release
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      rdy <= 1'b0;
    end else begin
      rdy <= 1'b1;
    end
  end

  assign trn = vld & rdy;

  //////////////////////////////
  // decode
  //////////////////////////////

  logic               err_c;
  logic [tcb_bew-1:0] ben_c;
  tcb_data_u          wdt_u;
  tcb_data_u          dat_c;

  // alignment check against the size
  always_comb begin
    case (siz)
      tcb_siz_byte: err_c = 1'b0;
      tcb_siz_half: err_c = adr[0];
      tcb_siz_word: err_c = |adr[1:0];
      default:      err_c = 1'b1;
    endcase
  end

  // byte enables from size and offset
  always_comb begin
    case (siz)
      tcb_siz_byte: ben_c = tcb_bew'(4'b0001) << adr[1:0];
      tcb_siz_half: ben_c = tcb_bew'(4'b0011) << adr[1:0];
      default:      ben_c = '1;
    endcase
    // an error must never touch memory
    if (err_c) ben_c = '0;
  end

  // right-justified write data moved up to its lanes
  // a rotation is enough, unused lanes are masked by ben
  assign wdt_u.wrd = wdt;

  always_comb begin
    dat_c = '0;
    for (int i = 0; i < tcb_bew; i++) begin
      dat_c.lane[i] = wdt_u.lane[2'(i) - adr[1:0]];
    end
  end

  //////////////////////////////
  // stage registers
  //////////////////////////////

  // valid bit
  always_ff @(posedge tcb or negedge rst_n) begin
    if (!rst_n) begin
      req.vld <= 1'b0;
    end else begin
      req.vld <= trn;
    end
  end

  // payload, loaded only on a transfer
  always_ff @(posedge tcb) begin
    if (trn) begin
      req.wen <= wen;
      req.err <= err_c;
      req.idx <= adr[ABW-1:2];
      req.off <= adr[1:0];
      req.siz <= siz;
      req.ben <= ben_c;
      req.dat <= dat_c;
    end
  end

  // request fields must be known whenever a transfer is taken
  a_req_known: assert property (
    @(posedge tcb) disable iff (!rst_n)
    trn |-> !$isunknown({wen, siz, adr})
  );

endmodule : tcb_req_stage

// ==== source/tcb_rsp_stage.sv ====
module tcb_rsp_stage
  import tcb_pkg::*;
#(
  parameter int unsigned DLY = 3,
  parameter int unsigned ABW = 12
)(
  input  logic               tcb,
  input  logic               rst_n,
  // from the memory stage
  tcb_stage_if.dst           mem,
  // response to the manager
  output logic               rsp,
  output logic [tcb_dbw-1:0] rdt,
  output logic               err
);

  // two cycles are already spent upstream
  if (DLY < 2) begin : g_dly_check
    $error("tcb_rsp_stage: DLY must be at least 2, got %0d", DLY);
  end

  //////////////////////////////
  // lane extraction
  //////////////////////////////

  tcb_data_u          rot;
  logic [tcb_dbw-1:0] ext;
  logic [tcb_dbw-1:0] rdt_c;

  // bring the addressed lane down to lane 0
  always_comb begin
    rot = '0;
    for (int i = 0; i < tcb_bew; i++) begin
      rot.lane[i] = mem.dat.lane[2'(i) + mem.off];
    end
  end

  // zero extension by size
  always_comb begin
    case (mem.siz)
      tcb_siz_byte: ext = tcb_dbw'(rot.lane[0]);
      tcb_siz_half: ext = tcb_dbw'({rot.lane[1], rot.lane[0]});
      default:      ext = rot.wrd;
    endcase
  end

  // writes and errors return zero
  assign rdt_c = (mem.wen || mem.err) ? '0 : ext;

  //////////////////////////////
  // delay line
  //////////////////////////////

  if (DLY > 2) begin : g_pipe
    localparam int unsigned N = DLY - 2;

    logic [N-1:0]              vld_q;
    logic [N-1:0]              err_q;
    logic [N-1:0][tcb_dbw-1:0] rdt_q;

    // valid bits clear on reset
    always_ff @(posedge tcb or negedge rst_n) begin
      if (!rst_n) begin
        vld_q <= '0;
      end else begin
        vld_q[0] <= mem.vld;
        for (int i = 1; i < N; i++) begin
          vld_q[i] <= vld_q[i-1];
        end
      end
    end

    // payload shift, no reset needed
    always_ff @(posedge tcb) begin
      rdt_q[0] <= rdt_c;
      err_q[0] <= mem.err;
      for (int i = 1; i < N; i++) begin
        rdt_q[i] <= rdt_q[i-1];
        err_q[i] <= err_q[i-1];
      end
    end

    assign rsp = vld_q[N-1];
    assign rdt = rdt_q[N-1];
    assign err = err_q[N-1];
  end else begin : g_comb
    // DLY of 2, the memory register is the last stage
    assign rsp = mem.vld;
    assign rdt = rdt_c;
    assign err = mem.err;
  end

  // response strobe stays clean once out of reset
  a_rsp_known: assert property (
    @(posedge tcb) disable iff (!rst_n)
    !$isunknown(rsp)
  );

endmodule : tcb_rsp_stage

// ==== source/tcb_stage_if.sv ====
interface tcb_stage_if
  import tcb_pkg::*;
#(
  parameter int unsigned ABW = 12
);

  // stage holds a valid transfer
  logic               vld;
  // write enable
  logic               wen;
  // misaligned or unsupported size
  logic               err;
  // word index and byte offset within the word
  logic [ABW-3:0]     idx;
  logic [1:0]         off;
  // transfer size code
  logic [1:0]         siz;
  // byte enables, all zero on error
  logic [tcb_bew-1:0] ben;
  // lane aligned data, write or read depending on stage
  tcb_data_u          dat;

  // upstream stage drives everything
  modport src (output vld, wen, err, idx, off, siz, ben, dat);

  // downstream stage only listens
  modport dst (input  vld, wen, err, idx, off, siz, ben, dat);

endinterface : tcb_stage_if

// ==== tcb_mem_sub.f ====
source/tcb_pkg.sv
source/tcb_stage_if.sv
source/tcb_req_stage.sv
source/tcb_mem_stage.sv
source/tcb_rsp_stage.sv
source/tcb_mem_sub.sv
verif/tcb_clk_gen.sv
verif/tcb_mem_sub_tb.sv

// ==== verif/tcb_clk_gen.sv ====
module tcb_clk_gen #(
  parameter int unsigned HALF       = 10,
  parameter int unsigned RST_CYCLES = 2
)(
  output logic tcb,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // free running clock, 20 ns period
  initial begin
    tcb = 1'b0;
    forever #(HALF) tcb = ~tcb;
  end

  // reset held over the first edges, released on a rising edge
  initial begin
    rst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge tcb);
    rst_n <= 1'b1;
  end

endmodule : tcb_clk_gen

// ==== verif/tcb_mem_sub_tb.sv ====
module tcb_mem_sub_tb
  import tcb_pkg::*;
();

  timeunit 1ns;
  timeprecision 100ps;

  // must match the DUT defaults
  localparam int unsigned ABW = 12;
  localparam int unsigned DLY = 3;

  // transfer counts per test
  localparam int unsigned N_RESET = 2;
  localparam int unsigned N_WORD  = 8;
  localparam int unsigned N_SUB   = 14;
  localparam int unsigned N_ERR   = 4;
  localparam int unsigned N_FILL  = 16;
  localparam int unsigned N_RAND  = 200;
  localparam int unsigned N_ALL   = N_RESET + 2*N_WORD + N_SUB + N_ERR + N_FILL + N_RAND;
  localparam int unsigned LIMIT   = N_ALL * (DLY + 4) + 200;

  logic               tcb;
  logic               rst_n;
  logic               vld;
  logic               wen;
  logic [ABW-1:0]     adr;
  logic [1:0]         siz;
  logic [tcb_dbw-1:0] wdt;
  logic               rdy;
  logic               rsp;
  logic [tcb_dbw-1:0] rdt;
  logic               err;

  // cycle count, also the timing reference for responses
  int unsigned        cyc = 0;
  string              cur_test;
  logic [15:0]        lfsr;

  // reference copy of the memory
  logic [tcb_dbw-1:0] ref_mem [0:2**(ABW-2)-1];

  // expected responses, oldest first
  int unsigned        exp_cyc_q [$];
  logic [tcb_dbw-1:0] exp_rdt_q [$];
  logic               exp_err_q [$];
  string              exp_name_q [$];

  tcb_clk_gen u_clk (
    .tcb   (tcb),
    .rst_n (rst_n)
  );

  tcb_mem_sub dut (
    .tcb   (tcb),
    .rst_n (rst_n),
    .vld   (vld),
    .wen   (wen),
    .adr   (adr),
    .siz   (siz),
    .wdt   (wdt),
    .rdy   (rdy),
    .rsp   (rsp),
    .rdt   (rdt),
    .err   (err)
  );

  //////////////////////////////
  // helpers
  //////////////////////////////

  task automatic report_failure(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "simulation stopped on the first error");
  endtask

  // 16-bit fibonacci lfsr, taps 16 14 13 11
  function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  // one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // expected response of one transfer, updates ref_mem on writes
  function automatic void ref_access(
    input  logic               w,
    input  logic [ABW-1:0]     a,
    input  logic [1:0]         s,
    input  logic [tcb_dbw-1:0] d,
    output logic [tcb_dbw-1:0] r,
    output logic               e
  );
    int unsigned        nbytes;
    int unsigned        off;
    int unsigned        idx;
    logic [tcb_dbw-1:0] word;
    nbytes = 1 << s;
    off    = a % 4;
    idx    = a / 4;
    // unsupported size or address not a multiple of the size
    e = (s == 2'd3) || ((a % nbytes) != 0);
    r = '0;
    if (!e) begin
      word = ref_mem[idx];
      if (w) begin
        for (int b = 0; b < nbytes; b++) begin
          word[8*(off+b) +: 8] = d[8*b +: 8];
        end
        ref_mem[idx] = word;
      end else begin
        // right-justified, zero above the transfer size
        for (int b = 0; b < nbytes; b++) begin
          r[8*b +: 8] = word[8*(off+b) +: 8];
        end
      end
    end
  endfunction

  // present one request, return on the edge where it is taken
  task automatic issue_transfer(
    input logic               w,
    input logic [ABW-1:0]     a,
    input logic [1:0]         s,
    input logic [tcb_dbw-1:0] d
  );
    vld <= 1'b1;
    wen <= w;
    adr <= a;
    siz <= s;
    wdt <= d;
    do @(posedge tcb); while (!rdy);
  endtask

  task automatic wait_idle(input int unsigned n);
    vld <= 1'b0;
    repeat (n) @(posedge tcb);
  endtask

  // directed transfer followed by one idle cycle
  task automatic single_access(
    input logic               w,
    input logic [ABW-1:0]     a,
    input logic [1:0]         s,
    input logic [tcb_dbw-1:0] d
  );
    issue_transfer(w, a, s, d);
    wait_idle(1);
  endtask

  //////////////////////////////
  // cycle counter and timeout
  //////////////////////////////

  always @(posedge tcb) begin
    cyc <= cyc + 1;
    assert (cyc < LIMIT)
      else report_failure($sformatf("timeout, run still busy after %0d cycles", cyc));
  end

  //////////////////////////////
  // reference model and comparator
  //////////////////////////////

  // outputs sampled before this edge's updates
  always @(posedge tcb) begin
    logic [tcb_dbw-1:0] e_rdt;
    logic               e_err;
    if (!rst_n) begin
      // first edge still clears the flops
      if (cyc > 0) begin
        assert (rdy === 1'b0 && rsp === 1'b0)
          else report_failure("rdy or rsp went high while reset was asserted");
      end
    end else begin
      if (exp_cyc_q.size() > 0) begin
        assert (exp_cyc_q[0] >= cyc)
          else report_failure($sformatf("response missing, was due at cycle %0d",
                                        exp_cyc_q[0]));
      end
      if (rsp) begin
        assert (exp_cyc_q.size() > 0)
          else report_failure("response strobe with no transfer outstanding");
        assert (cyc == exp_cyc_q[0])
          else report_failure($sformatf("** Error %s: rsp cycle expected %0d, actual %0d",
                                        exp_name_q[0], exp_cyc_q[0], cyc));
        assert (rdt === exp_rdt_q[0])
          else report_failure($sformatf("** Error %s: rdt expected %h, actual %h",
                                        exp_name_q[0], exp_rdt_q[0], rdt));
        assert (err === exp_err_q[0])
          else report_failure($sformatf("** Error %s: err expected %b, actual %b",
                                        exp_name_q[0], exp_err_q[0], err));
        void'(exp_cyc_q.pop_front());
        void'(exp_rdt_q.pop_front());
        void'(exp_err_q.pop_front());
        void'(exp_name_q.pop_front());
      end
      // new transfer, response due DLY edges later
      if (vld && rdy) begin
        ref_access(wen, adr, siz, wdt, e_rdt, e_err);
        exp_cyc_q.push_back(cyc + DLY);
        exp_rdt_q.push_back(e_rdt);
        exp_err_q.push_back(e_err);
        exp_name_q.push_back(cur_test);
      end
    end
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////

  initial begin
    logic [ABW-1:0]     a;
    logic [1:0]         s;
    logic [1:0]         gap;
    logic [3:0]         r_idx;
    logic [1:0]         r_off;
    logic               w;
    logic [tcb_dbw-1:0] d;
    vld      = 1'b0;
    wen      = 1'b0;
    adr      = '0;
    siz      = '0;
    wdt      = '0;
    lfsr     = 16'd53;
    cur_test = "reset";

    // request waits through reset until rdy comes up
    @(posedge tcb);
    single_access(1'b1, 12'h000, tcb_siz_word, 32'hcafe_0001);
    single_access(1'b0, 12'h000, tcb_siz_word, '0);

    cur_test <= "word";
    for (int i = 0; i < N_WORD; i++) begin
      single_access(1'b1, ABW'(i * 'h248), tcb_siz_word, rand_bits(32));
    end
    for (int i = 0; i < N_WORD; i++) begin
      single_access(1'b0, ABW'(i * 'h248), tcb_siz_word, '0);
    end

    // upper wdt bits are junk, only the low lanes count
    cur_test <= "byte_half";
    single_access(1'b1, 12'h100, tcb_siz_word, 32'h1122_3344);
    single_access(1'b1, 12'h104, tcb_siz_word, 32'h5566_7788);
    single_access(1'b1, 12'h101, tcb_siz_byte, 32'hffff_ffa1);
    single_access(1'b1, 12'h106, tcb_siz_byte, 32'h1234_56b2);
    single_access(1'b1, 12'h102, tcb_siz_half, 32'hdead_c3d4);
    single_access(1'b1, 12'h104, tcb_siz_half, 32'hbeef_1e5f);
    for (int i = 0; i < 4; i++) begin
      single_access(1'b0, ABW'('h100 + i), tcb_siz_byte, '0);
    end
    single_access(1'b0, 12'h104, tcb_siz_half, '0);
    single_access(1'b0, 12'h106, tcb_siz_half, '0);
    single_access(1'b0, 12'h100, tcb_siz_word, '0);
    single_access(1'b0, 12'h104, tcb_siz_word, '0);

    // none of these may change word 0x100
    cur_test <= "errors";
    single_access(1'b1, 12'h101, tcb_siz_half, 32'h0000_aaaa);
    single_access(1'b1, 12'h102, tcb_siz_word, 32'hbbbb_bbbb);
    single_access(1'b1, 12'h100, 2'd3, 32'hcccc_cccc);
    single_access(1'b0, 12'h100, tcb_siz_word, '0);

    // fill the window first so random reads never hit unwritten words
    cur_test <= "pipelined_random";
    for (int i = 0; i < N_FILL; i++) begin
      a = ABW'('h300 + 4*i);
      issue_transfer(1'b1, a, tcb_siz_word, {a, 8'h5a, ~a});
    end
    for (int i = 0; i < N_RAND; i++) begin
      gap = 2'(rand_bits(2));
      if (gap != 0) begin
        wait_idle(gap);
      end
      s = 2'(rand_bits(2));
      if (s == 2'd3) begin
        s = tcb_siz_word;
      end
      // aligned offset inside the 16 word window at 0x300
      r_idx = 4'(rand_bits(4));
      r_off = 2'(rand_bits(2)) & ~((2'd1 << s) - 2'd1);
      a = {4'h3, 2'b00, r_idx, r_off};
      w = 1'(rand_bits(1));
      d = rand_bits(32);
      issue_transfer(w, a, s, d);
    end
    wait_idle(1);

    // drain, then a quiet stretch to catch stray responses
    while (exp_cyc_q.size() != 0) begin
      @(posedge tcb);
    end
    wait_idle(DLY + 2);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule : tcb_mem_sub_tb
